/* design/rename_pkg.sv */
// shared widths, types and reset state for the rename stage
// architectural register 0 is hardwired to physical register 0 and is never renamed
// the RAT packs entry i at bits [i*PREG_W +: PREG_W]
package rename_pkg;

    localparam int BUNDLE_WIDTH = 4;
    localparam int ARCH_REGS = 8;
    localparam int PHYS_REGS = 32;

    localparam int ARCH_W = $clog2(ARCH_REGS);
    localparam int PREG_W = $clog2(PHYS_REGS);
    localparam int OPCODE_W = 4;

    typedef logic [ARCH_W-1:0] arch_reg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [PHYS_REGS-1:0] preg_mask_t;
    typedef logic [ARCH_REGS*PREG_W-1:0] rat_t;
    typedef logic [BUNDLE_WIDTH-1:0] slot_mask_t;

    // identity mapping, arch reg i lives in phys reg i
    function automatic rat_t reset_rat();
        rat_t r;
        for (int i = 0; i < ARCH_REGS; i++) begin
            r[i*PREG_W +: PREG_W] = preg_t'(i);
        end
        return r;
    endfunction

    localparam rat_t RESET_RAT = reset_rat();

    // the first ARCH_REGS physical registers hold the reset mapping
    localparam preg_mask_t RESET_FREE = {{(PHYS_REGS-ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};

    // every physical register starts out with a valid value
    localparam preg_mask_t RESET_READY = {PHYS_REGS{1'b1}};

endpackage

/* design/rename_bundle_latch.sv */
// holds one bundle of micro-ops and tracks which slots are still to be handed out
// a new bundle may enter on the same edge as the last slot of the old one leaves
// in_ready has a combinational path from out_fire
module rename_bundle_latch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  rename_pkg::opcode_t   in_opcode [rename_pkg::BUNDLE_WIDTH],
    input  rename_pkg::arch_reg_t in_dst    [rename_pkg::BUNDLE_WIDTH],
    input  rename_pkg::arch_reg_t in_src1   [rename_pkg::BUNDLE_WIDTH],
    input  rename_pkg::arch_reg_t in_src2   [rename_pkg::BUNDLE_WIDTH],
    input  rename_pkg::slot_mask_t out_fire,
    output logic                  in_ready,
    output logic                  bundle_live,
    output logic                  bundle_done,
    output rename_pkg::slot_mask_t slots_pending,
    output rename_pkg::opcode_t   lat_opcode [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::arch_reg_t lat_dst    [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::arch_reg_t lat_src1   [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::arch_reg_t lat_src2   [rename_pkg::BUNDLE_WIDTH]
);

    rename_pkg::slot_mask_t pending_next;
    logic accept;

    // slots left once this cycle's handshakes are done
    assign pending_next = slots_pending & ~out_fire;

    assign bundle_live = (slots_pending != '0);
    assign in_ready = (pending_next == '0);
    assign bundle_done = bundle_live && (pending_next == '0);
    assign accept = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            slots_pending <= '0;
        end else if (accept) begin
            slots_pending <= '1;
        end else begin
            slots_pending <= pending_next;
        end
    end

    // micro-op fields only change on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            lat_opcode <= in_opcode;
            lat_dst <= in_dst;
            lat_src1 <= in_src1;
            lat_src2 <= in_src2;
        end
    end

endmodule

/* design/rename_cell.sv */
// renames one micro-op against the RAT/free/ready view handed in from the previous slot
// purely combinational; the updated view is chained into the next slot
// when the free view is empty a writing micro-op reports alloc_ok low and changes nothing
module rename_cell (
    input  rename_pkg::opcode_t    opcode,
    input  rename_pkg::arch_reg_t  dst,
    input  rename_pkg::arch_reg_t  src1,
    input  rename_pkg::arch_reg_t  src2,
    input  rename_pkg::rat_t       rat_in,
    input  rename_pkg::preg_mask_t free_in,
    input  rename_pkg::preg_mask_t ready_in,
    output rename_pkg::rat_t       rat_out,
    output rename_pkg::preg_mask_t free_out,
    output rename_pkg::preg_mask_t ready_out,
    output logic                   alloc_ok,
    output logic                   writes,
    output rename_pkg::opcode_t    opcode_out,
    output rename_pkg::preg_t      dst_preg,
    output rename_pkg::preg_t      old_preg,
    output rename_pkg::preg_t      src1_preg,
    output rename_pkg::preg_t      src2_preg,
    output logic                   src1_rdy,
    output logic                   src2_rdy
);

    rename_pkg::preg_t pick;
    logic found;
    logic do_alloc;

    // priority search, lowest index wins
    always_comb begin : lowest_free
        found = 1'b0;
        pick = '0;
        for (int i = rename_pkg::PHYS_REGS - 1; i >= 0; i--) begin
            if (free_in[i]) begin
                found = 1'b1;
                pick = rename_pkg::preg_t'(i);
            end
        end
    end

    assign writes = (dst != '0);
    assign do_alloc = writes && found;
    assign alloc_ok = !writes || found;

    assign opcode_out = opcode;

    // sources see the view before this micro-op's own rename
    assign src1_preg = (src1 == '0) ? '0 : rat_in[src1*rename_pkg::PREG_W +: rename_pkg::PREG_W];
    assign src2_preg = (src2 == '0) ? '0 : rat_in[src2*rename_pkg::PREG_W +: rename_pkg::PREG_W];
    assign src1_rdy = (src1 == '0) || ready_in[src1_preg];
    assign src2_rdy = (src2 == '0) || ready_in[src2_preg];

    assign dst_preg = do_alloc ? pick : '0;
    assign old_preg = rat_in[dst*rename_pkg::PREG_W +: rename_pkg::PREG_W];

    always_comb begin : view_update
        rat_out = rat_in;
        free_out = free_in;
        ready_out = ready_in;
        if (do_alloc) begin
            rat_out[dst*rename_pkg::PREG_W +: rename_pkg::PREG_W] = pick;
            free_out[pick] = 1'b0;
            // new destination is not ready until completion reports it
            ready_out[pick] = 1'b0;
        end
    end

endmodule

/* design/rename_state.sv */
// architectural rename state: RAT, free pool and ready bits
// one commit free and one completion per cycle
// frees are parked in a pending mask while a bundle holds its allocations
module rename_state (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   bundle_live,
    input  logic                   bundle_done,
    input  rename_pkg::slot_mask_t slots_pending,
    input  logic                   free_valid,
    input  rename_pkg::preg_t      free_preg,
    input  logic                   done_valid,
    input  rename_pkg::preg_t      done_preg,
    input  rename_pkg::rat_t       end_rat,
    input  rename_pkg::preg_mask_t end_free,
    input  rename_pkg::preg_mask_t end_ready,
    output rename_pkg::rat_t       cur_rat,
    output rename_pkg::preg_mask_t cur_free,
    output rename_pkg::preg_mask_t cur_ready
);

    rename_pkg::preg_mask_t pend_free;
    rename_pkg::preg_mask_t free_mask;
    rename_pkg::preg_mask_t done_mask;
    logic merge_ok;

    always_comb begin
        free_mask = '0;
        // phys reg 0 backs the zero register and never re-enters the pool
        if (free_valid && (free_preg != '0)) begin
            free_mask[free_preg] = 1'b1;
        end
    end

    always_comb begin
        done_mask = '0;
        if (done_valid) begin
            done_mask[done_preg] = 1'b1;
        end
    end

    // slots_pending here only shows slots held back from the output,
    // so all ones means the live bundle is stalled and nothing has left yet
    assign merge_ok = !bundle_live || (slots_pending == '1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_rat <= rename_pkg::RESET_RAT;
            cur_free <= rename_pkg::RESET_FREE;
            cur_ready <= rename_pkg::RESET_READY;
            pend_free <= '0;
        end else if (bundle_done) begin
            // commit the view left behind by the last slot
            cur_rat <= end_rat;
            cur_free <= end_free | pend_free | free_mask;
            cur_ready <= end_ready | done_mask;
            pend_free <= '0;
        end else begin
            cur_ready <= cur_ready | done_mask;
            if (merge_ok) begin
                cur_free <= cur_free | pend_free | free_mask;
                pend_free <= '0;
            end else begin
                pend_free <= pend_free | free_mask;
            end
        end
    end

endmodule

/* design/rename_top.sv */
// rename stage, four micro-ops per bundle, all slots offered together once the pool covers them
// slots may then be taken in any order; in_ready waits for the last one
// a bundle that cannot allocate stalls until commit frees refill the pool
module rename_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  rename_pkg::opcode_t    in_opcode [rename_pkg::BUNDLE_WIDTH],
    input  rename_pkg::arch_reg_t  in_dst    [rename_pkg::BUNDLE_WIDTH],
    input  rename_pkg::arch_reg_t  in_src1   [rename_pkg::BUNDLE_WIDTH],
    input  rename_pkg::arch_reg_t  in_src2   [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::slot_mask_t out_valid,
    input  rename_pkg::slot_mask_t out_ready,
    output rename_pkg::opcode_t    out_opcode    [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::preg_t      out_dst_preg  [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::preg_t      out_old_preg  [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::preg_t      out_src1_preg [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::preg_t      out_src2_preg [rename_pkg::BUNDLE_WIDTH],
    output rename_pkg::slot_mask_t out_src1_rdy,
    output rename_pkg::slot_mask_t out_src2_rdy,
    output rename_pkg::slot_mask_t out_writes,
    input  logic                   free_valid,
    input  rename_pkg::preg_t      free_preg,
    input  logic                   done_valid,
    input  rename_pkg::preg_t      done_preg
);

    rename_pkg::opcode_t lat_opcode [rename_pkg::BUNDLE_WIDTH];
    rename_pkg::arch_reg_t lat_dst [rename_pkg::BUNDLE_WIDTH];
    rename_pkg::arch_reg_t lat_src1 [rename_pkg::BUNDLE_WIDTH];
    rename_pkg::arch_reg_t lat_src2 [rename_pkg::BUNDLE_WIDTH];

    rename_pkg::slot_mask_t slots_pending;
    rename_pkg::slot_mask_t slots_held;
    rename_pkg::slot_mask_t out_fire;
    rename_pkg::slot_mask_t alloc_ok;
    logic bundle_live;
    logic bundle_done;
    logic all_ok;

    // view chain, entry 0 from the state block, last entry back into it
    rename_pkg::rat_t chain_rat [rename_pkg::BUNDLE_WIDTH+1];
    rename_pkg::preg_mask_t chain_free [rename_pkg::BUNDLE_WIDTH+1];
    rename_pkg::preg_mask_t chain_ready [rename_pkg::BUNDLE_WIDTH+1];

    assign all_ok = &alloc_ok;
    assign out_valid = {rename_pkg::BUNDLE_WIDTH{bundle_live && all_ok}} & slots_pending;
    assign out_fire = out_valid & out_ready;

    // pending but not offered, the state block merges frees only while all are held
    assign slots_held = slots_pending & ~out_valid;

    rename_bundle_latch latch_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_opcode     (in_opcode),
        .in_dst        (in_dst),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .out_fire      (out_fire),
        .in_ready      (in_ready),
        .bundle_live   (bundle_live),
        .bundle_done   (bundle_done),
        .slots_pending (slots_pending),
        .lat_opcode    (lat_opcode),
        .lat_dst       (lat_dst),
        .lat_src1      (lat_src1),
        .lat_src2      (lat_src2)
    );

    rename_state state_i (
        .clk           (clk),
        .rst           (rst),
        .bundle_live   (bundle_live),
        .bundle_done   (bundle_done),
        .slots_pending (slots_held),
        .free_valid    (free_valid),
        .free_preg     (free_preg),
        .done_valid    (done_valid),
        .done_preg     (done_preg),
        .end_rat       (chain_rat[rename_pkg::BUNDLE_WIDTH]),
        .end_free      (chain_free[rename_pkg::BUNDLE_WIDTH]),
        .end_ready     (chain_ready[rename_pkg::BUNDLE_WIDTH]),
        .cur_rat       (chain_rat[0]),
        .cur_free      (chain_free[0]),
        .cur_ready     (chain_ready[0])
    );

    for (genvar k = 0; k < rename_pkg::BUNDLE_WIDTH; k++) begin : g_slot
        rename_cell cell_i (
            .opcode     (lat_opcode[k]),
            .dst        (lat_dst[k]),
            .src1       (lat_src1[k]),
            .src2       (lat_src2[k]),
            .rat_in     (chain_rat[k]),
            .free_in    (chain_free[k]),
            .ready_in   (chain_ready[k]),
            .rat_out    (chain_rat[k+1]),
            .free_out   (chain_free[k+1]),
            .ready_out  (chain_ready[k+1]),
            .alloc_ok   (alloc_ok[k]),
            .writes     (out_writes[k]),
            .opcode_out (out_opcode[k]),
            .dst_preg   (out_dst_preg[k]),
            .old_preg   (out_old_preg[k]),
            .src1_preg  (out_src1_preg[k]),
            .src2_preg  (out_src2_preg[k]),
            .src1_rdy   (out_src1_rdy[k]),
            .src2_rdy   (out_src2_rdy[k])
        );
    end

endmodule

/* testbench/rename_tb.sv */
// self-checking testbench for rename_top with a slot-by-slot reference model
// bundles go in one at a time and each is drained before the next one is sent
// frees return old mappings handed out earlier and completions only come between bundles
module rename_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS = 6;
    localparam int BUNDLES_PER_TEST = 10;
    localparam int BW = rename_pkg::BUNDLE_WIDTH;
    localparam int NA = rename_pkg::ARCH_REGS;

    logic clk;
    logic rst;
    logic in_valid;
    logic in_ready;
    rename_pkg::opcode_t in_opcode [BW];
    rename_pkg::arch_reg_t in_dst [BW];
    rename_pkg::arch_reg_t in_src1 [BW];
    rename_pkg::arch_reg_t in_src2 [BW];
    rename_pkg::slot_mask_t out_valid;
    rename_pkg::slot_mask_t out_ready;
    rename_pkg::opcode_t out_opcode [BW];
    rename_pkg::preg_t out_dst_preg [BW];
    rename_pkg::preg_t out_old_preg [BW];
    rename_pkg::preg_t out_src1_preg [BW];
    rename_pkg::preg_t out_src2_preg [BW];
    rename_pkg::slot_mask_t out_src1_rdy;
    rename_pkg::slot_mask_t out_src2_rdy;
    rename_pkg::slot_mask_t out_writes;
    logic free_valid;
    rename_pkg::preg_t free_preg;
    logic done_valid;
    rename_pkg::preg_t done_preg;

    // model state with the RAT as an unpacked table
    rename_pkg::preg_t m_rat [NA];
    rename_pkg::preg_mask_t m_free;
    rename_pkg::preg_mask_t m_ready;
    rename_pkg::preg_mask_t m_pend;
    logic m_live;
    logic m_covered;
    rename_pkg::slot_mask_t m_left;
    // view after the last slot of the live bundle
    rename_pkg::preg_t e_rat [NA];
    rename_pkg::preg_mask_t e_free;
    rename_pkg::preg_mask_t e_ready;
    // fields of the next bundle
    rename_pkg::opcode_t b_opcode [BW];
    rename_pkg::arch_reg_t b_dst [BW];
    rename_pkg::arch_reg_t b_src1 [BW];
    rename_pkg::arch_reg_t b_src2 [BW];
    // expected slot outputs
    rename_pkg::opcode_t exp_opcode [BW];
    rename_pkg::preg_t exp_dst [BW];
    rename_pkg::preg_t exp_old [BW];
    rename_pkg::preg_t exp_src1 [BW];
    rename_pkg::preg_t exp_src2 [BW];
    rename_pkg::slot_mask_t exp_rdy1;
    rename_pkg::slot_mask_t exp_rdy2;
    rename_pkg::slot_mask_t exp_writes;

    rename_pkg::preg_t retire_q [$];
    logic [31:0] lfsr_state;
    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;
    rename_pkg::slot_mask_t fire;
    logic accept;

    assign fire = out_valid & out_ready;
    assign accept = in_valid && in_ready;

    rename_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_opcode     (in_opcode),
        .in_dst        (in_dst),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_opcode    (out_opcode),
        .out_dst_preg  (out_dst_preg),
        .out_old_preg  (out_old_preg),
        .out_src1_preg (out_src1_preg),
        .out_src2_preg (out_src2_preg),
        .out_src1_rdy  (out_src1_rdy),
        .out_src2_rdy  (out_src2_rdy),
        .out_writes    (out_writes),
        .free_valid    (free_valid),
        .free_preg     (free_preg),
        .done_valid    (done_valid),
        .done_preg     (done_preg)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] got,
                                            input logic [31:0] want);
        errors++;
        $display("mismatch %s got %h expected %h", name, got, want);
    endfunction

    function automatic void report_failure(input string what);
        errors++;
        $display("%s", what);
    endfunction

    function automatic void reset_model();
        for (int a = 0; a < NA; a++) begin
            m_rat[a] = rename_pkg::preg_t'(a);
        end
        m_free = '0;
        for (int p = NA; p < rename_pkg::PHYS_REGS; p++) begin
            m_free[p] = 1'b1;
        end
        m_ready = '1;
        m_pend = '0;
        m_live = 1'b0;
        m_covered = 1'b1;
        m_left = '0;
    endfunction

    // walk the slots in order so that each one sees the renames of the slots before it
    function automatic void predict_bundle();
        int writers;
        int pick;
        writers = 0;
        for (int a = 0; a < NA; a++) begin
            e_rat[a] = m_rat[a];
        end
        e_free = m_free;
        e_ready = m_ready;
        for (int k = 0; k < BW; k++) begin
            exp_opcode[k] = b_opcode[k];
            exp_src1[k] = (b_src1[k] == '0) ? '0 : e_rat[b_src1[k]];
            exp_src2[k] = (b_src2[k] == '0) ? '0 : e_rat[b_src2[k]];
            exp_rdy1[k] = (b_src1[k] == '0) || e_ready[exp_src1[k]];
            exp_rdy2[k] = (b_src2[k] == '0) || e_ready[exp_src2[k]];
            exp_writes[k] = (b_dst[k] != '0);
            exp_old[k] = e_rat[b_dst[k]];
            exp_dst[k] = '0;
            if (exp_writes[k]) begin
                writers++;
                pick = -1;
                for (int p = 0; p < rename_pkg::PHYS_REGS; p++) begin
                    if (pick < 0 && e_free[p]) begin
                        pick = p;
                    end
                end
                if (pick >= 0) begin
                    exp_dst[k] = rename_pkg::preg_t'(pick);
                    e_rat[b_dst[k]] = exp_dst[k];
                    e_free[pick] = 1'b0;
                    e_ready[pick] = 1'b0;
                end
            end
        end
        m_covered = (writers <= $countones(m_free));
    endfunction

    function automatic void commit_bundle();
        for (int a = 0; a < NA; a++) begin
            m_rat[a] = e_rat[a];
        end
        m_free = e_free | m_pend;
        m_ready = e_ready;
        m_pend = '0;
        m_live = 1'b0;
        for (int k = 0; k < BW; k++) begin
            if (exp_writes[k]) begin
                retire_q.push_back(exp_old[k]);
            end
        end
    endfunction

    function automatic void random_fields();
        for (int k = 0; k < BW; k++) begin
            b_opcode[k] = rename_pkg::opcode_t'(lfsr_bits(rename_pkg::OPCODE_W));
            b_dst[k] = rename_pkg::arch_reg_t'(lfsr_bits(rename_pkg::ARCH_W));
            b_src1[k] = rename_pkg::arch_reg_t'(lfsr_bits(rename_pkg::ARCH_W));
            b_src2[k] = rename_pkg::arch_reg_t'(lfsr_bits(rename_pkg::ARCH_W));
        end
    endfunction

    // tasks start and end 2 units after a rising edge
    task automatic send_bundle();
        in_valid = 1'b1;
        for (int k = 0; k < BW; k++) begin
            in_opcode[k] = b_opcode[k];
            in_dst[k] = b_dst[k];
            in_src1[k] = b_src1[k];
            in_src2[k] = b_src2[k];
        end
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        m_live = 1'b1;
        m_left = '1;
        predict_bundle();
    endtask

    task automatic drain_bundle(input bit random_ready);
        rename_pkg::slot_mask_t taken;
        while (m_left != '0) begin
            if (random_ready) begin
                out_ready = rename_pkg::slot_mask_t'(lfsr_bits(BW));
            end else begin
                out_ready = '1;
            end
            taken = m_left & out_ready;
            @(posedge clk);
            #2;
            m_left = m_left & ~taken;
        end
        out_ready = '0;
        commit_bundle();
    endtask

    task automatic free_reg(input rename_pkg::preg_t p);
        free_valid = 1'b1;
        free_preg = p;
        @(posedge clk);
        #2;
        free_valid = 1'b0;
        if (p != '0) begin
            // a bundle on offer keeps its allocations and the free waits for bundle_done
            if (m_live && m_covered) begin
                m_pend[p] = 1'b1;
            end else begin
                m_free[p] = 1'b1;
                if (m_live) begin
                    predict_bundle();
                end
            end
        end
    endtask

    task automatic return_retired();
        while (retire_q.size() > 0) begin
            free_reg(retire_q.pop_front());
        end
    endtask

    task automatic complete_reg(input rename_pkg::preg_t p);
        done_valid = 1'b1;
        done_preg = p;
        @(posedge clk);
        #2;
        done_valid = 1'b0;
        m_ready[p] = 1'b1;
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - errors_at_start;
        tests_run++;
        if (n == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, n);
        end
        errors_at_start = errors;
    endtask

    for (genvar k = 0; k < BW; k++) begin : g_slot_check
        assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> out_opcode[k] == exp_opcode[k])
            else report_mismatch($sformatf("out_opcode[%0d]", k),
                32'($sampled(out_opcode[k])), 32'(exp_opcode[k]));
        assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> out_writes[k] == exp_writes[k])
            else report_mismatch($sformatf("out_writes[%0d]", k),
                32'($sampled(out_writes[k])), 32'(exp_writes[k]));
        assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> out_dst_preg[k] == exp_dst[k])
            else report_mismatch($sformatf("out_dst_preg[%0d]", k),
                32'($sampled(out_dst_preg[k])), 32'(exp_dst[k]));
        assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> out_old_preg[k] == exp_old[k])
            else report_mismatch($sformatf("out_old_preg[%0d]", k),
                32'($sampled(out_old_preg[k])), 32'(exp_old[k]));
        assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> out_src1_preg[k] == exp_src1[k])
            else report_mismatch($sformatf("out_src1_preg[%0d]", k),
                32'($sampled(out_src1_preg[k])), 32'(exp_src1[k]));
        assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> out_src2_preg[k] == exp_src2[k])
            else report_mismatch($sformatf("out_src2_preg[%0d]", k),
                32'($sampled(out_src2_preg[k])), 32'(exp_src2[k]));
        assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> out_src1_rdy[k] == exp_rdy1[k])
            else report_mismatch($sformatf("out_src1_rdy[%0d]", k),
                32'($sampled(out_src1_rdy[k])), 32'(exp_rdy1[k]));
        assert property (@(posedge clk) disable iff (rst)
            fire[k] |-> out_src2_rdy[k] == exp_rdy2[k])
            else report_mismatch($sformatf("out_src2_rdy[%0d]", k),
                32'($sampled(out_src2_rdy[k])), 32'(exp_rdy2[k]));
        assert property (@(posedge clk) disable iff (rst)
            out_valid[k] && !out_ready[k] |=> out_valid[k]
                && $stable(out_opcode[k]) && $stable(out_writes[k])
                && $stable(out_dst_preg[k]) && $stable(out_old_preg[k])
                && $stable(out_src1_preg[k]) && $stable(out_src2_preg[k])
                && $stable(out_src1_rdy[k]) && $stable(out_src2_rdy[k]))
            else report_failure($sformatf("slot %0d dropped or changed while held", k));
        assert property (@(posedge clk) disable iff (rst)
            fire[k] && !accept |=> !out_valid[k])
            else report_failure($sformatf("slot %0d stayed valid after its transfer", k));
    end

    assert property (@(posedge clk) disable iff (rst)
        m_live && !m_covered |-> out_valid == '0)
        else report_failure("a slot was valid while the free pool was short");
    assert property (@(posedge clk) disable iff (rst)
        m_live && m_covered |-> out_valid == m_left)
        else report_mismatch("out_valid", 32'($sampled(out_valid)), 32'(m_left));
    assert property (@(posedge clk) disable iff (rst)
        (m_left & ~fire) != '0 |-> !in_ready)
        else report_failure("in_ready rose before every slot of the bundle was taken");
    assert property (@(posedge clk) disable iff (rst)
        !m_live |-> in_ready)
        else report_failure("in_ready was low with no bundle live");

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * BUNDLES_PER_TEST * 40));
        $display("timeout, the run did not finish in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin : main
        lfsr_state = 32'h451a02bf;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        in_valid = 1'b0;
        for (int k = 0; k < BW; k++) begin
            in_opcode[k] = '0;
            in_dst[k] = '0;
            in_src1[k] = '0;
            in_src2[k] = '0;
        end
        out_ready = '0;
        free_valid = 1'b0;
        free_preg = '0;
        done_valid = 1'b0;
        done_preg = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        assert (in_ready && out_valid == '0)
            else report_failure("in_ready low or a slot valid right after reset");
        @(posedge clk);
        #2;

        // every source of the first bundle reads its reset mapping
        for (int k = 0; k < BW; k++) begin
            b_opcode[k] = rename_pkg::opcode_t'(k + 1);
            b_dst[k] = '0;
            b_src1[k] = rename_pkg::arch_reg_t'(2 * k + 1);
            b_src2[k] = rename_pkg::arch_reg_t'((2 * k + 2) % NA);
        end
        send_bundle();
        drain_bundle(1'b0);
        finish_test("reset mapping");

        random_fields();
        for (int k = 0; k < BW; k++) begin
            b_dst[k] = rename_pkg::arch_reg_t'(k + 1);
        end
        send_bundle();
        drain_bundle(1'b0);
        finish_test("allocation order");

        // chain of readers behind earlier writers of the same bundle
        random_fields();
        b_dst[0] = 3'd5;
        b_src1[0] = 3'd1;
        b_dst[1] = 3'd6;
        b_src1[1] = 3'd5;
        b_dst[2] = 3'd7;
        b_src1[2] = 3'd6;
        b_src2[2] = 3'd5;
        b_dst[3] = 3'd5;
        b_src1[3] = 3'd7;
        send_bundle();
        drain_bundle(1'b0);
        finish_test("dependencies within a bundle");

        for (int i = 0; i < 6; i++) begin
            random_fields();
            send_bundle();
            drain_bundle(1'b1);
            return_retired();
        end
        finish_test("per-slot back-pressure");

        // four writers per bundle until one no longer fits in the pool
        m_covered = 1'b1;
        while (m_covered) begin
            random_fields();
            for (int k = 0; k < BW; k++) begin
                b_dst[k] = rename_pkg::arch_reg_t'(k + 1);
            end
            send_bundle();
            if (m_covered) begin
                drain_bundle(1'b0);
            end
        end
        repeat (3) @(posedge clk);
        #2;
        while (!m_covered) begin
            free_reg(retire_q.pop_front());
        end
        // this one arrives while the bundle is on offer and has to wait
        free_reg(retire_q.pop_front());
        drain_bundle(1'b0);
        random_fields();
        for (int k = 0; k < BW; k++) begin
            b_dst[k] = '0;
        end
        b_dst[2] = 3'd3;
        send_bundle();
        drain_bundle(1'b0);
        return_retired();
        finish_test("free-pool exhaustion");

        random_fields();
        for (int k = 0; k < BW; k++) begin
            b_dst[k] = '0;
        end
        b_dst[0] = 3'd1;
        send_bundle();
        drain_bundle(1'b0);
        random_fields();
        for (int k = 0; k < BW; k++) begin
            b_dst[k] = '0;
        end
        b_src1[0] = 3'd1;
        send_bundle();
        drain_bundle(1'b0);
        complete_reg(m_rat[1]);
        random_fields();
        for (int k = 0; k < BW; k++) begin
            b_dst[k] = '0;
        end
        b_src1[1] = 3'd1;
        b_src2[3] = 3'd1;
        send_bundle();
        drain_bundle(1'b0);
        finish_test("completion");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* rename_top.f */
design/rename_pkg.sv
design/rename_bundle_latch.sv
design/rename_cell.sv
design/rename_state.sv
design/rename_top.sv
testbench/rename_tb.sv

/* Makefile */
# Verilator build and run for the rename stage testbench

VERILATOR ?= verilator
TOP ?= rename_tb
FILELIST ?= rename_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
